// ==== logic/tk_glue_pkg.sv ====
//==========================================================
// Shared widths, constants and packed types for the board glue
// around the home-computer core. Referenced by scoped names only.
//==========================================================

package tk_glue_pkg;

	//==========================================================
	// Widths and constants
	//==========================================================

	// Keyboard matrix size as seen by the core
	localparam int unsigned KBD_ROWS = 32'd8;
	localparam int unsigned KBD_COLS = 32'd6;

	// Main RAM port
	localparam int unsigned RAM_AW = 32'd16;
	localparam int unsigned RAM_DW = 32'd8;

	// Power-up flag byte, cleared while reset is held so a warm start
	// goes through the cold start path of the ROM
	localparam logic [RAM_AW-1:0] CLEAR_ADDR = 16'h03F4;

	//==========================================================
	// Types
	//==========================================================

	typedef logic [KBD_ROWS-1:0] kbd_row_t;
	typedef logic [KBD_COLS-1:0] kbd_col_t;

	// Joystick contacts, all active high
	typedef struct packed {
		logic fire2;
		logic fire1;
		logic up;
		logic down;
		logic left;
		logic right;
	} joy_t;

	// One RAM request: write enable, address and write data
	typedef struct packed {
		logic              we;
		logic [RAM_AW-1:0] addr;
		logic [RAM_DW-1:0] data;
	} ram_port_t;

	// Reset sources besides rst_n_i, each active high
	typedef struct packed {
		logic user_btn;
		logic menu_reset;
		logic download;
	} reset_req_t;

	// Per-drive image state
	typedef struct packed {
		logic mounted;
		logic change;
	} disk_stat_t;

endpackage

// ==== logic/reset_sequencer.sv ====
//==========================================================
// Stretches any reset request into a long core reset and takes
// over the RAM port meanwhile to clear the power-up flag byte.
//==========================================================
`timescale 1ns/100ps

module reset_sequencer #(
	// Quiet cycles needed before the core leaves reset
	parameter int unsigned HOLD_CYCLES = 4194304
) (
	input  logic                   clk_sys,
	input  logic                   rst_n_i,
	input  tk_glue_pkg::reset_req_t rst_req_i,
	input  tk_glue_pkg::ram_port_t  ram_core_i,
	output logic                   core_rst_o,
	output tk_glue_pkg::ram_port_t  ram_o
);

	// Counter wide enough to reach HOLD_CYCLES
	localparam int CW = $clog2(HOLD_CYCLES + 1);

	logic          req_any;
	logic [CW-1:0] hold_cnt;

	// Any request source, board reset included
	assign req_any = (|rst_req_i) | ~rst_n_i;

	//==========================================================
	// Hold counter
	//==========================================================

	// A request restarts the count from zero
	// The count runs only while the core is still held
	always_ff @(posedge clk_sys) begin
		if (req_any) begin
			core_rst_o <= 1'b1;
			hold_cnt   <= '0;
		end else if (core_rst_o) begin
			// Last quiet cycle of the hold
			if (hold_cnt == CW'(HOLD_CYCLES - 1)) begin
				core_rst_o <= 1'b0;
			end
			hold_cnt <= hold_cnt + CW'(1);
		end
	end

	//==========================================================
	// RAM port guard
	//==========================================================

	// While held, write zero to the flag byte every cycle
	// Otherwise the core owns the port
	always_comb begin
		if (core_rst_o) begin
			ram_o.we   = 1'b1;
			ram_o.addr = tk_glue_pkg::CLEAR_ADDR;
			ram_o.data = '0;
		end else begin
			ram_o = ram_core_i;
		end
	end

	// Core is in reset the cycle after any request
	a_req_holds_core: assert property (
		@(posedge clk_sys) req_any |=> core_rst_o
	);

endmodule

// ==== logic/joy_key_merge.sv ====
//==========================================================
// Maps joystick contacts onto keyboard matrix keys, arrows for
// the directions and two keys for the fire buttons.
//==========================================================
`timescale 1ns/100ps

module joy_key_merge (
	input  logic                  clk_sys,
	input  logic                  rst_n_i,
	input  tk_glue_pkg::kbd_row_t kbd_rows_i,
	input  tk_glue_pkg::kbd_col_t kbd_cols_i,
	input  tk_glue_pkg::joy_t     joy_i,
	output tk_glue_pkg::kbd_col_t kbd_cols_o
);

	// Column bits raised by the joystick this cycle
	tk_glue_pkg::kbd_col_t joy_cols;

	//==========================================================
	// Joystick to matrix mapping
	//==========================================================

	always_comb begin
		joy_cols = '0;
		// Arrow keys all return on column 0
		// Rows 6..3 are up, down, right, left
		joy_cols[0] = (kbd_rows_i[6] & joy_i.up)
			| (kbd_rows_i[5] & joy_i.down)
			| (kbd_rows_i[4] & joy_i.right)
			| (kbd_rows_i[3] & joy_i.left);
		// Fire 1 sits on row 7, column 4
		joy_cols[4] = kbd_rows_i[7] & joy_i.fire1;
		// Fire 2 sits on row 1, column 5
		joy_cols[5] = kbd_rows_i[1] & joy_i.fire2;
	end

	// Keys from the keyboard always pass, joystick only adds bits
	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			kbd_cols_o <= '0;
		end else begin
			kbd_cols_o <= kbd_cols_i | joy_cols;
		end
	end

	// A pressed key is never masked by the merge
	a_keys_pass: assert property (
		@(posedge clk_sys) rst_n_i |=> ((kbd_cols_o & $past(kbd_cols_i)) == $past(kbd_cols_i))
	);

endmodule

// ==== logic/disk_mount_track.sv ====
//==========================================================
// Per-drive image mount state and change toggle for the floppy
// side, plus the shared disk activity LED.
//==========================================================
`timescale 1ns/100ps

module disk_mount_track #(
	// Number of floppy drives
	parameter int unsigned DRIVES = 2
) (
	input  logic                                 clk_sys,
	input  logic                                 rst_n_i,
	input  logic [DRIVES-1:0]                    img_mounted_i,
	input  logic [63:0]                          img_size_i,
	input  logic [DRIVES-1:0]                    drive_active_i,
	output tk_glue_pkg::disk_stat_t [DRIVES-1:0] disk_o,
	output logic                                 led_o
);

	// Empty image means the drive was ejected
	logic size_nz;

	assign size_nz = |img_size_i;

	//==========================================================
	// Mount state
	//==========================================================

	// Image size is shared, so only the pulsed drive takes it
	// The change bit flips on every mount event, eject included
	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			disk_o <= '0;
		end else begin
			for (int d = 0; d < DRIVES; d++) begin
				if (img_mounted_i[d]) begin
					disk_o[d].mounted <= size_nz;
					disk_o[d].change  <= ~disk_o[d].change;
				end
			end
		end
	end

	//==========================================================
	// Activity LED
	//==========================================================

	// Lit while any drive motor is running
	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			led_o <= 1'b0;
		end else begin
			led_o <= |drive_active_i;
		end
	end

	// Host mounts one image at a time, size is only valid for one drive
	a_one_mount: assert property (
		@(posedge clk_sys) disable iff (!rst_n_i) $onehot0(img_mounted_i)
	);

endmodule

// ==== logic/tk_glue_top.sv ====
//==========================================================
// Board glue top level. Joins reset stretching, joystick merge
// and disk tracking; instantiate beside the emulated core.
//==========================================================
`timescale 1ns/100ps

module tk_glue_top #(
	// Reset stretch, about 0.3 s at 14 MHz on hardware
	parameter int unsigned HOLD_CYCLES = 4194304,
	parameter int unsigned DRIVES      = 2
) (
	input  logic                                 clk_sys,
	input  logic                                 rst_n_i,

	// Reset sources and RAM path
	input  tk_glue_pkg::reset_req_t              rst_req_i,
	input  tk_glue_pkg::ram_port_t               ram_core_i,
	output logic                                 core_rst_o,
	output tk_glue_pkg::ram_port_t               ram_o,

	// Keyboard matrix and joystick
	input  tk_glue_pkg::kbd_row_t                kbd_rows_i,
	input  tk_glue_pkg::kbd_col_t                kbd_cols_i,
	input  tk_glue_pkg::joy_t                    joy_i,
	output tk_glue_pkg::kbd_col_t                kbd_cols_o,

	// Disk images and activity
	input  logic [DRIVES-1:0]                    img_mounted_i,
	input  logic [63:0]                          img_size_i,
	input  logic [DRIVES-1:0]                    drive_active_i,
	output tk_glue_pkg::disk_stat_t [DRIVES-1:0] disk_o,
	output logic                                 led_o
);

	//==========================================================
	// Reset and RAM guard
	//==========================================================

	reset_sequencer #(
		.HOLD_CYCLES (HOLD_CYCLES)
	) u_reset_sequencer (
		.clk_sys    (clk_sys),
		.rst_n_i    (rst_n_i),
		.rst_req_i  (rst_req_i),
		.ram_core_i (ram_core_i),
		.core_rst_o (core_rst_o),
		.ram_o      (ram_o)
	);

	//==========================================================
	// Keyboard and joystick
	//==========================================================

	// Registered columns go back to the core scanner
	joy_key_merge u_joy_key_merge (
		.clk_sys    (clk_sys),
		.rst_n_i    (rst_n_i),
		.kbd_rows_i (kbd_rows_i),
		.kbd_cols_i (kbd_cols_i),
		.joy_i      (joy_i),
		.kbd_cols_o (kbd_cols_o)
	);

	//==========================================================
	// Disk status
	//==========================================================

	disk_mount_track #(
		.DRIVES (DRIVES)
	) u_disk_mount_track (
		.clk_sys        (clk_sys),
		.rst_n_i        (rst_n_i),
		.img_mounted_i  (img_mounted_i),
		.img_size_i     (img_size_i),
		.drive_active_i (drive_active_i),
		.disk_o         (disk_o),
		.led_o          (led_o)
	);

endmodule

// ==== tests/tb_clock.sv ====
//==========================================================
// Free running testbench clock, 10 ns period by default
//==========================================================
`timescale 1ns/100ps

module tb_clock #(
	// Half period in ns
	parameter int HALF_PERIOD = 5
) (
	output logic clk_o
);

	// Starts low so the first rising edge lands at HALF_PERIOD
	initial begin
		clk_o = 1'b0;
		forever #(HALF_PERIOD) clk_o = ~clk_o;
	end

endmodule

// ==== tests/tb_top.sv ====
//==========================================================
// Testbench for the board glue top level. Random stimulus, a
// reference model checked every cycle, watchdog and final report.
//==========================================================
`timescale 1ns/100ps

module tb_top;

	localparam int unsigned HOLD_CYCLES = 64;
	localparam int unsigned DRIVES      = 2;

	// Watchdog allows twice the summed test lengths in cycles
	localparam int RESET_CYCLES   = 10;
	localparam int STRETCH_CYCLES = 6 * (HOLD_CYCLES + 10);
	localparam int JOY_CYCLES     = 500;
	localparam int DISK_PULSES    = 40;
	localparam int LED_CYCLES     = 300;
	localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + STRETCH_CYCLES + JOY_CYCLES
		+ 3 * DISK_PULSES + LED_CYCLES);

	logic                                 clk_sys;
	logic                                 rst_n_i;
	tk_glue_pkg::reset_req_t              rst_req_i;
	tk_glue_pkg::ram_port_t               ram_core_i;
	logic                                 core_rst_o;
	tk_glue_pkg::ram_port_t               ram_o;
	tk_glue_pkg::kbd_row_t                kbd_rows_i;
	tk_glue_pkg::kbd_col_t                kbd_cols_i;
	tk_glue_pkg::joy_t                    joy_i;
	tk_glue_pkg::kbd_col_t                kbd_cols_o;
	logic [DRIVES-1:0]                    img_mounted_i;
	logic [63:0]                          img_size_i;
	logic [DRIVES-1:0]                    drive_active_i;
	tk_glue_pkg::disk_stat_t [DRIVES-1:0] disk_o;
	logic                                 led_o;

	// Reference model state starts at the reset values
	logic                                 exp_rst = 1'b1;
	int                                   quiet = 0;
	tk_glue_pkg::ram_port_t               exp_ram;
	tk_glue_pkg::kbd_col_t                exp_kbd = '0;
	tk_glue_pkg::disk_stat_t [DRIVES-1:0] exp_disk = '0;
	logic                                 exp_led = 1'b0;
	logic [31:0]                          rng = 32'h68bc0999;

	// Set by the first rising edge, outputs are unknown before it
	logic                                 armed = 1'b0;

	tb_clock #(.HALF_PERIOD(5)) u_clock (.clk_o(clk_sys));

	tk_glue_top #(
		.HOLD_CYCLES (HOLD_CYCLES),
		.DRIVES      (DRIVES)
	) uut (
		.clk_sys        (clk_sys),
		.rst_n_i        (rst_n_i),
		.rst_req_i      (rst_req_i),
		.ram_core_i     (ram_core_i),
		.core_rst_o     (core_rst_o),
		.ram_o          (ram_o),
		.kbd_rows_i     (kbd_rows_i),
		.kbd_cols_i     (kbd_cols_i),
		.joy_i          (joy_i),
		.kbd_cols_o     (kbd_cols_o),
		.img_mounted_i  (img_mounted_i),
		.img_size_i     (img_size_i),
		.drive_active_i (drive_active_i),
		.disk_o         (disk_o),
		.led_o          (led_o)
	);

	//==========================================================
	// Reference functions
	//==========================================================

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Arrows on column 0, fire 1 on row 7 col 4, fire 2 on row 1 col 5
	function automatic tk_glue_pkg::kbd_col_t ref_cols(input tk_glue_pkg::kbd_row_t rows,
		input tk_glue_pkg::kbd_col_t cols, input tk_glue_pkg::joy_t joy);
		tk_glue_pkg::kbd_col_t c;
		c = cols;
		if ((rows[6] && joy.up) || (rows[5] && joy.down)
			|| (rows[4] && joy.right) || (rows[3] && joy.left)) begin
			c[0] = 1'b1;
		end
		if (rows[7] && joy.fire1) begin
			c[4] = 1'b1;
		end
		if (rows[1] && joy.fire2) begin
			c[5] = 1'b1;
		end
		return c;
	endfunction

	// Held core gets its port replaced by a zero write to the flag byte
	function automatic tk_glue_pkg::ram_port_t ref_ram(input logic held,
		input tk_glue_pkg::ram_port_t core);
		tk_glue_pkg::ram_port_t p;
		p = core;
		if (held) begin
			p.we   = 1'b1;
			p.addr = 16'h03F4;
			p.data = 8'h00;
		end
		return p;
	endfunction

	// Mount pulse loads the size test and flips change
	function automatic tk_glue_pkg::disk_stat_t ref_disk(input tk_glue_pkg::disk_stat_t cur,
		input logic pulse, input logic [63:0] size);
		tk_glue_pkg::disk_stat_t s;
		s = cur;
		if (pulse) begin
			s.mounted = (size != 64'd0);
			s.change  = ~cur.change;
		end
		return s;
	endfunction

	//==========================================================
	// Checking
	//==========================================================

	task automatic report_mismatch(input string name, input logic [63:0] exp_v,
		input logic [63:0] got_v);
		$display("mismatch at %0t ns: %s expected 0x%0h got 0x%0h", $time, name, exp_v, got_v);
		$display("TEST FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	always @(posedge clk_sys) begin
		armed <= 1'b1;
	end

	// Outputs are stable at the falling edge
	// Check first, then step the model with the inputs of the next rising edge
	always @(negedge clk_sys) begin
		if (armed) begin
			assert (core_rst_o === exp_rst)
				else report_mismatch("core_rst_o", 64'(exp_rst), 64'(core_rst_o));
			exp_ram = ref_ram(exp_rst, ram_core_i);
			assert (ram_o === exp_ram)
				else report_mismatch("ram_o", 64'(exp_ram), 64'(ram_o));
			assert (kbd_cols_o === exp_kbd)
				else report_mismatch("kbd_cols_o", 64'(exp_kbd), 64'(kbd_cols_o));
			assert (disk_o === exp_disk)
				else report_mismatch("disk_o", 64'(exp_disk), 64'(disk_o));
			assert (led_o === exp_led)
				else report_mismatch("led_o", 64'(exp_led), 64'(led_o));
			// Quiet cycles since the last request saturate at the hold length
			if (rst_req_i != '0 || !rst_n_i) begin
				quiet = 0;
			end else if (quiet < int'(HOLD_CYCLES)) begin
				quiet++;
			end
			exp_rst = (quiet < int'(HOLD_CYCLES));
			if (!rst_n_i) begin
				exp_kbd  = '0;
				exp_disk = '0;
				exp_led  = 1'b0;
			end else begin
				exp_kbd = ref_cols(kbd_rows_i, kbd_cols_i, joy_i);
				for (int d = 0; d < int'(DRIVES); d++) begin
					exp_disk[d] = ref_disk(exp_disk[d], img_mounted_i[d], img_size_i);
				end
				exp_led = (drive_active_i != '0);
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("timeout: stimulus still running after %0d cycles", WATCHDOG_CYCLES);
		$display("TEST FAILED");
		$fatal(1, "watchdog expired");
	end

	//==========================================================
	// Stimulus
	//==========================================================

	task automatic draw(output logic [31:0] r);
		rng = xorshift32(rng);
		r = rng;
	endtask

	// One clock with a fresh random core RAM request
	task automatic tick();
		logic [31:0] r;
		@(posedge clk_sys);
		draw(r);
		ram_core_i <= r[24:0];
	endtask

	// Counts cycles from request removal to the release of core_rst_o
	task automatic check_release();
		int   n;
		logic released;
		n        = 0;
		released = 1'b0;
		while (!released && n <= 4 * int'(HOLD_CYCLES)) begin
			tick();
			@(negedge clk_sys);
			n++;
			released = !core_rst_o;
		end
		if (!released) begin
			$display("core_rst_o was never released after the reset request ended");
			$display("TEST FAILED");
			$fatal(1, "reset release missing");
		end else begin
			assert (n == int'(HOLD_CYCLES))
				else report_mismatch("core_rst_o release delay", 64'(HOLD_CYCLES), 64'(n));
		end
	endtask

	// One cycle request from a reset_req_t field or from rst_n_i
	task automatic pulse_request(input tk_glue_pkg::reset_req_t req, input logic board);
		tick();
		if (board) begin
			rst_n_i <= 1'b0;
		end else begin
			rst_req_i <= req;
		end
		tick();
		rst_n_i   <= 1'b1;
		rst_req_i <= '0;
		check_release();
	endtask

	initial begin : stimulus
		logic [31:0]       r;
		logic [31:0]       r_hi;
		logic [31:0]       r_lo;
		int                d;
		logic [DRIVES-1:0] pulse;
		rst_n_i        <= 1'b0;
		rst_req_i      <= '0;
		ram_core_i     <= '0;
		kbd_rows_i     <= '0;
		kbd_cols_i     <= '0;
		joy_i          <= '0;
		img_mounted_i  <= '0;
		img_size_i     <= '0;
		drive_active_i <= '0;
		repeat (RESET_CYCLES) tick();
		rst_n_i <= 1'b1;
		check_release();

		// Reset stretch from each source in turn
		for (int i = 0; i < 3; i++) begin
			pulse_request(tk_glue_pkg::reset_req_t'(3'b001 << i), 1'b0);
		end
		pulse_request('0, 1'b1);

		// Second request halfway through the hold restarts the count
		tick();
		rst_req_i <= 3'b100;
		tick();
		rst_req_i <= '0;
		repeat (30) tick();
		rst_req_i <= 3'b010;
		tick();
		rst_req_i <= '0;
		check_release();

		// Joystick merge
		repeat (JOY_CYCLES) begin
			tick();
			draw(r);
			kbd_rows_i <= r[7:0];
			kbd_cols_i <= r[13:8];
			joy_i      <= r[19:14];
		end
		tick();
		kbd_rows_i <= '0;
		kbd_cols_i <= '0;
		joy_i      <= '0;

		// Mount pulses with empty and non-empty images on random drives
		repeat (DISK_PULSES) begin
			tick();
			draw(r);
			draw(r_hi);
			draw(r_lo);
			d        = int'(r % DRIVES);
			pulse    = '0;
			pulse[d] = 1'b1;
			img_mounted_i <= pulse;
			img_size_i    <= r[8] ? {r_hi, r_lo | 32'd1} : 64'd0;
			tick();
			// Size noise without a pulse must change nothing
			img_mounted_i <= '0;
			img_size_i    <= {r_lo, r_hi};
			tick();
		end

		// Activity LED
		repeat (LED_CYCLES) begin
			tick();
			draw(r);
			drive_active_i <= r[DRIVES-1:0];
		end
		tick();
		drive_active_i <= '0;
		repeat (4) tick();
		$display("TEST OK");
		$finish;
	end

endmodule

// ==== list.f ====
logic/tk_glue_pkg.sv
logic/reset_sequencer.sv
logic/joy_key_merge.sv
logic/disk_mount_track.sv
logic/tk_glue_top.sv
tests/tb_clock.sv
tests/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it
# The exit status is non-zero when the run fails
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module tb_top \
	-Mdir obj_dir -o tb_top -f list.f &&
./obj_dir/tb_top || exit 1
exit 0
